// File: source/cnn_accel_pkg.sv
package cnn_accel_pkg;

  // sizes
  localparam int NUM_CLASS   = 4;                      // output classes, one bank each
  localparam int NUM_FEAT    = 16;                     // features per vector, bank depth
  localparam int TOTAL_WORDS = NUM_CLASS * NUM_FEAT;   // words copied per load
  localparam int SRAM_AW     = 16;                     // external weight sram address
  localparam int BANK_AW     = 4;                      // on-chip bank address
  localparam int CLASS_W     = 2;                      // class index bits

  // data types
  typedef logic signed [15:0] weight_t;                // fc weight
  typedef logic signed [7:0]  feat_t;                  // pooled feature
  typedef logic signed [31:0] acc_t;                   // dot product and score
  typedef logic [CLASS_W-1:0] class_idx_t;             // winning class

  // weight loader states
  typedef enum logic [1:0] {
    DMA_IDLE,                                          // waiting for start
    DMA_READ,                                          // streaming sram addresses
    DMA_DRAIN                                          // last write, then finish
  } dma_state_t;

  // classifier states
  typedef enum logic [1:0] {
    FC_IDLE,                                           // nothing to add
    FC_ACC,                                            // products landing
    FC_RESULT                                          // argmax and clear
  } fc_state_t;

endpackage

// File: source/weight_bank_if.sv
`timescale 1ns/1ns

interface weight_bank_if;

  logic [cnn_accel_pkg::NUM_CLASS-1:0] wr_en;          // one write strobe per bank
  logic [cnn_accel_pkg::BANK_AW-1:0]   wr_addr;        // word index inside bank
  cnn_accel_pkg::weight_t              wr_data;        // shared write data
  logic [cnn_accel_pkg::BANK_AW-1:0]   rd_addr;        // feature index from classifier
  // net, since each bank drives its own slot
  wire cnn_accel_pkg::weight_t [cnn_accel_pkg::NUM_CLASS-1:0] rd_data;

  modport dma (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_addr,
    input  rd_data
  );

  modport bank (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: source/weight_dma.sv
`timescale 1ns/1ns

module weight_dma (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 i_start,             // already gated by busy
  input  cnn_accel_pkg::weight_t               i_sram_weight,       // sram data, 1 cycle late
  output logic [cnn_accel_pkg::SRAM_AW-1:0]    o_sram_weight_addr,
  output logic                                 o_finish,
  weight_bank_if.dma                           bus
);

  cnn_accel_pkg::dma_state_t              state;
  logic [cnn_accel_pkg::SRAM_AW-1:0]      rd_ptr;         // address going out to sram
  logic                                   drain_done;     // last write has landed
  logic [cnn_accel_pkg::NUM_CLASS-1:0]    bank_sel;       // decoded from upper bits

  assign o_sram_weight_addr = rd_ptr;
  assign bus.wr_data        = i_sram_weight;              // sram output goes straight in

  // word c*NUM_FEAT+k lives in bank c, so upper bits pick the bank
  always_comb begin
    bank_sel = '0;
    bank_sel[rd_ptr[cnn_accel_pkg::BANK_AW +: cnn_accel_pkg::CLASS_W]] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= cnn_accel_pkg::DMA_IDLE;
      rd_ptr     <= '0;
      drain_done <= 1'b0;
      o_finish   <= 1'b0;
    end else begin
      o_finish <= 1'b0;                                   // single cycle pulse
      case (state)
        cnn_accel_pkg::DMA_IDLE: begin
          rd_ptr     <= '0;
          drain_done <= 1'b0;
          if (i_start) begin
            state <= cnn_accel_pkg::DMA_READ;             // address 0 already out
          end
        end
        cnn_accel_pkg::DMA_READ: begin
          if (rd_ptr == cnn_accel_pkg::TOTAL_WORDS - 1) begin
            rd_ptr <= '0;                                 // park address at 0
            state  <= cnn_accel_pkg::DMA_DRAIN;
          end else begin
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        cnn_accel_pkg::DMA_DRAIN: begin
          if (drain_done) begin
            o_finish   <= 1'b1;                           // 2 cycles after last addr
            drain_done <= 1'b0;
            state      <= cnn_accel_pkg::DMA_IDLE;
          end else begin
            drain_done <= 1'b1;                           // final word written here
          end
        end
        default: begin
          state <= cnn_accel_pkg::DMA_IDLE;
        end
      endcase
    end
  end

  // write side trails the read address by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.wr_en <= '0;
    end else if (state == cnn_accel_pkg::DMA_READ) begin
      bus.wr_en <= bank_sel;                              // data arrives next cycle
    end else begin
      bus.wr_en <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == cnn_accel_pkg::DMA_READ) begin
      bus.wr_addr <= rd_ptr[cnn_accel_pkg::BANK_AW-1:0];  // word index in bank
    end
  end

  // top must block restarts for the whole load
  a_start_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_start |-> state == cnn_accel_pkg::DMA_IDLE
  ) else $error("weight_dma: start seen while loading");

endmodule

// File: source/weight_bank.sv
`timescale 1ns/1ns

module weight_bank (
  input  logic                               clk,
  input  logic                               i_wr_en,      // this bank's strobe
  input  logic [cnn_accel_pkg::BANK_AW-1:0]  i_addr,       // muxed dma / classifier addr
  input  cnn_accel_pkg::weight_t             i_wr_data,
  output cnn_accel_pkg::weight_t             o_rd_data     // valid 1 cycle after addr
);

  cnn_accel_pkg::weight_t mem [cnn_accel_pkg::NUM_FEAT];  // one class worth of weights

  // write first, read data follows the written word
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_addr] <= i_wr_data;
      o_rd_data   <= i_wr_data;                           // bypass on write
    end else begin
      o_rd_data   <= mem[i_addr];
    end
  end

  // address mux in top must be settled during dma writes
  a_addr_known : assert property (
    @(posedge clk)
    i_wr_en |-> !$isunknown(i_addr)
  ) else $error("weight_bank: unknown address on write");

endmodule

// File: source/fc_classifier.sv
`timescale 1ns/1ns

module fc_classifier (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cnn_accel_pkg::feat_t         i_feat,
  input  logic                         i_feat_valid,   // already gated with ready
  input  logic                         i_feat_last,    // last feature of vector
  weight_bank_if.reader                rd,
  output cnn_accel_pkg::class_idx_t    o_class,
  output cnn_accel_pkg::acc_t          o_score,
  output logic                         o_valid
);

  logic [cnn_accel_pkg::BANK_AW:0]     feat_cnt;       // one extra bit to catch overrun
  logic [cnn_accel_pkg::BANK_AW-1:0]   rd_addr_q;      // address sampled by banks next edge
  cnn_accel_pkg::feat_t                s1_feat;
  cnn_accel_pkg::feat_t                s2_feat;        // lines up with bank data
  logic                                s1_valid;
  logic                                s2_valid;
  logic                                s1_last;
  logic                                s2_last;
  cnn_accel_pkg::acc_t                 prod [cnn_accel_pkg::NUM_CLASS];
  cnn_accel_pkg::acc_t                 acc  [cnn_accel_pkg::NUM_CLASS];
  cnn_accel_pkg::fc_state_t            state;
  cnn_accel_pkg::class_idx_t           best_idx;
  cnn_accel_pkg::acc_t                 best_score;

  assign rd.rd_addr = rd_addr_q;

  // stage 1, issue read address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_cnt  <= '0;
      rd_addr_q <= '0;
      s1_valid  <= 1'b0;
      s1_last   <= 1'b0;
    end else begin
      s1_valid <= i_feat_valid;
      s1_last  <= i_feat_valid & i_feat_last;
      if (i_feat_valid) begin
        rd_addr_q <= feat_cnt[cnn_accel_pkg::BANK_AW-1:0];
        // cleared on accept so next vector may follow at once
        feat_cnt  <= i_feat_last ? '0 : feat_cnt + 1'b1;
      end
    end
  end

  // stage 2, wait for bank read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_feat_valid) begin
      s1_feat <= i_feat;
    end
    s2_feat <= s1_feat;
  end

  // signed feature times weight, one per class
  always_comb begin
    for (int c = 0; c < cnn_accel_pkg::NUM_CLASS; c++) begin
      prod[c] = cnn_accel_pkg::acc_t'(s2_feat) *
                cnn_accel_pkg::acc_t'(cnn_accel_pkg::weight_t'(rd.rd_data[c]));
    end
  end

  // accumulate, result state restarts sums from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < cnn_accel_pkg::NUM_CLASS; c++) begin
        acc[c] <= '0;
      end
      state <= cnn_accel_pkg::FC_IDLE;
    end else begin
      for (int c = 0; c < cnn_accel_pkg::NUM_CLASS; c++) begin
        acc[c] <= ((state == cnn_accel_pkg::FC_RESULT) ? '0 : acc[c]) +
                  (s2_valid ? prod[c] : '0);               // new vector may add here
      end
      if (s2_valid && s2_last) begin
        state <= cnn_accel_pkg::FC_RESULT;                 // sums are final next cycle
      end else if (s2_valid) begin
        state <= cnn_accel_pkg::FC_ACC;
      end else begin
        state <= cnn_accel_pkg::FC_IDLE;
      end
    end
  end

  // argmax, strict compare keeps lower index on ties
  always_comb begin
    best_idx   = '0;
    best_score = acc[0];
    for (int c = 1; c < cnn_accel_pkg::NUM_CLASS; c++) begin
      if (acc[c] > best_score) begin
        best_score = acc[c];
        best_idx   = cnn_accel_pkg::class_idx_t'(c);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= (state == cnn_accel_pkg::FC_RESULT);      // 3 cycles after last
    end
  end

  always_ff @(posedge clk) begin
    if (state == cnn_accel_pkg::FC_RESULT) begin
      o_class <= best_idx;
      o_score <= best_score;
    end
  end

  // vector longer than a bank would wrap the read address
  a_cnt_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    feat_cnt <= cnn_accel_pkg::NUM_FEAT
  ) else $error("fc_classifier: feature count past bank depth");

endmodule

// File: source/cnn_accel_top.sv
`timescale 1ns/1ns

module cnn_accel_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_start,            // host load pulse
  input  cnn_accel_pkg::weight_t             i_sram_weight,
  input  cnn_accel_pkg::feat_t               i_feat,
  input  logic                               i_feat_valid,
  input  logic                               i_feat_last,
  output logic [cnn_accel_pkg::SRAM_AW-1:0]  o_sram_weight_addr,
  output logic                               o_dma_finish,
  output logic                               o_data_ready,       // banks hold valid weights
  output cnn_accel_pkg::class_idx_t          o_result_class,
  output cnn_accel_pkg::acc_t                o_result_score,
  output logic                               o_result_valid
);

  logic dma_busy;                                  // load in progress
  logic start_ok;                                  // start outside a load
  logic feat_valid_ok;                             // feature counted by classifier

  weight_bank_if bank_bus ();

  assign start_ok      = i_start & ~dma_busy;
  assign feat_valid_ok = i_feat_valid & o_data_ready;   // drop features until loaded

  // busy from start until finish pulse, ready after that
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dma_busy     <= 1'b0;
      o_data_ready <= 1'b0;
    end else begin
      if (start_ok) begin
        dma_busy     <= 1'b1;
        o_data_ready <= 1'b0;                      // reload invalidates banks
      end else if (o_dma_finish) begin
        dma_busy     <= 1'b0;
        o_data_ready <= 1'b1;
      end
    end
  end

  weight_dma u_dma (
    .clk                (clk),
    .rst_n              (rst_n),
    .i_start            (start_ok),
    .i_sram_weight      (i_sram_weight),
    .o_sram_weight_addr (o_sram_weight_addr),
    .o_finish           (o_dma_finish),
    .bus                (bank_bus.dma)
  );

  for (genvar c = 0; c < cnn_accel_pkg::NUM_CLASS; c++) begin : g_bank
    logic [cnn_accel_pkg::BANK_AW-1:0] bank_addr;  // dma owns the banks while busy

    assign bank_addr = dma_busy ? bank_bus.wr_addr : bank_bus.rd_addr;

    weight_bank u_bank (
      .clk       (clk),
      .i_wr_en   (bank_bus.wr_en[c]),
      .i_addr    (bank_addr),
      .i_wr_data (bank_bus.wr_data),
      .o_rd_data (bank_bus.rd_data[c])
    );
  end

  fc_classifier u_fc (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_feat       (i_feat),
    .i_feat_valid (feat_valid_ok),
    .i_feat_last  (i_feat_last),
    .rd           (bank_bus.reader),
    .o_class      (o_result_class),
    .o_score      (o_result_score),
    .o_valid      (o_result_valid)
  );

  // finish from the dma only ends a load this level started
  a_finish_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    o_dma_finish |-> dma_busy
  ) else $error("cnn_accel_top: dma finish without a load");

endmodule

// File: verification/cnn_accel_tb.sv
`timescale 1ns/1ns

module cnn_accel_tb;

  typedef cnn_accel_pkg::feat_t feat_vec_t [cnn_accel_pkg::NUM_FEAT];  // one input vector

  // six tests, each one load plus a few vectors
  localparam int TIMEOUT_CYC =
    6 * (cnn_accel_pkg::TOTAL_WORDS + 3 * cnn_accel_pkg::NUM_FEAT + 20);

  logic                               clk = 1'b0;
  logic                               rst_n;
  logic                               i_start;
  cnn_accel_pkg::weight_t             sram_q;              // registered sram read data
  cnn_accel_pkg::feat_t               i_feat;
  logic                               i_feat_valid;
  logic                               i_feat_last;
  logic [cnn_accel_pkg::SRAM_AW-1:0]  o_sram_weight_addr;
  logic                               o_dma_finish;
  logic                               o_data_ready;
  cnn_accel_pkg::class_idx_t          o_result_class;
  cnn_accel_pkg::acc_t                o_result_score;
  logic                               o_result_valid;

  cnn_accel_pkg::weight_t    sram_mem [cnn_accel_pkg::TOTAL_WORDS];  // external weight sram
  integer                    seed;
  int                        cycle_cnt = 0;                // edges since time 0
  int                        error_cnt = 0;
  int                        check_cnt = 0;
  int                        test_cnt  = 0;
  cnn_accel_pkg::class_idx_t res_class_q [$];              // results seen on o_result_valid
  cnn_accel_pkg::acc_t       res_score_q [$];
  int                        res_cyc_q [$];                // edge after which valid was high
  int                        last_cyc_q [$];               // edge that took the last feature
  feat_vec_t                 saved_vec;                    // reused by the reload test

  always #5 clk = ~clk;                                    // 10 ns period

  always @(posedge clk) begin
    sram_q <= sram_mem[o_sram_weight_addr];                // one cycle read latency
  end

  // result monitor, samples values settled after the previous edge
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (o_result_valid === 1'b1) begin
      res_class_q.push_back(o_result_class);
      res_score_q.push_back(o_result_score);
      res_cyc_q.push_back(cycle_cnt - 1);
    end
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  cnn_accel_top uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .i_start            (i_start),
    .i_sram_weight      (sram_q),
    .i_feat             (i_feat),
    .i_feat_valid       (i_feat_valid),
    .i_feat_last        (i_feat_last),
    .o_sram_weight_addr (o_sram_weight_addr),
    .o_dma_finish       (o_dma_finish),
    .o_data_ready       (o_data_ready),
    .o_result_class     (o_result_class),
    .o_result_score     (o_result_score),
    .o_result_valid     (o_result_valid)
  );

  task automatic step();
    @(posedge clk);
    #1;                                                    // drive point after the edge
  endtask

  task automatic check_bit(input logic act, input logic exp, input string msg);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %0t ns: %s is %b, expected %b", $time, msg, act, exp);
      error_cnt++;
    end
  endtask

  task automatic check_addr(input logic [cnn_accel_pkg::SRAM_AW-1:0] act,
                            input logic [cnn_accel_pkg::SRAM_AW-1:0] exp, input string msg);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %0t ns: %s is %0d, expected %0d", $time, msg, act, exp);
      error_cnt++;
    end
  endtask

  task automatic check_class(input cnn_accel_pkg::class_idx_t act,
                             input cnn_accel_pkg::class_idx_t exp, input string msg);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %0t ns: %s class %0d, expected %0d", $time, msg, act, exp);
      error_cnt++;
    end
  endtask

  task automatic check_score(input cnn_accel_pkg::acc_t act,
                             input cnn_accel_pkg::acc_t exp, input string msg);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %0t ns: %s score %0d, expected %0d", $time, msg, act, exp);
      error_cnt++;
    end
  endtask

  task automatic apply_reset();
    i_start      = 1'b0;
    i_feat       = '0;
    i_feat_valid = 1'b0;
    i_feat_last  = 1'b0;
    rst_n        = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    res_class_q.delete();
    res_score_q.delete();
    res_cyc_q.delete();
    last_cyc_q.delete();
  endtask

  // dot product per class from sram layout c*NUM_FEAT+k, ties keep lower index
  task automatic ref_classify(input feat_vec_t v, output cnn_accel_pkg::class_idx_t cls,
                              output cnn_accel_pkg::acc_t score);
    int sum [cnn_accel_pkg::NUM_CLASS];
    for (int c = 0; c < cnn_accel_pkg::NUM_CLASS; c++) begin
      sum[c] = 0;
      for (int k = 0; k < cnn_accel_pkg::NUM_FEAT; k++) begin
        sum[c] += int'(v[k]) * int'(sram_mem[c * cnn_accel_pkg::NUM_FEAT + k]);
      end
    end
    cls   = '0;
    score = sum[0];
    for (int c = 1; c < cnn_accel_pkg::NUM_CLASS; c++) begin
      if (sum[c] > int'(score)) begin
        score = sum[c];
        cls   = cnn_accel_pkg::class_idx_t'(c);
      end
    end
  endtask

  task automatic fill_pattern(input int salt);
    for (int a = 0; a < cnn_accel_pkg::TOTAL_WORDS; a++) begin
      sram_mem[a] = cnn_accel_pkg::weight_t'((a * 73 + salt) % 211 - 105);
    end
  endtask

  task automatic fill_random();
    for (int a = 0; a < cnn_accel_pkg::TOTAL_WORDS; a++) begin
      sram_mem[a] = cnn_accel_pkg::weight_t'($random(seed));
    end
  endtask

  task automatic random_vector(output feat_vec_t v);
    for (int k = 0; k < cnn_accel_pkg::NUM_FEAT; k++) begin
      v[k] = cnn_accel_pkg::feat_t'($random(seed));
    end
  endtask

  // start pulse, address walk, finish pulse and ready level
  task automatic load_weights(input bit check_timing);
    int waited;
    i_start = 1'b1;
    step();                                                // edge 0 takes the start
    i_start = 1'b0;
    check_bit(o_data_ready, 1'b0, "o_data_ready after start");
    if (check_timing) check_addr(o_sram_weight_addr, '0, "sram address after edge 0");
    for (int n = 1; n < cnn_accel_pkg::TOTAL_WORDS; n++) begin
      step();
      if (check_timing) check_addr(o_sram_weight_addr, n, "sram address");
    end
    waited = cnn_accel_pkg::TOTAL_WORDS - 1;
    while (!o_dma_finish && waited < cnn_accel_pkg::TOTAL_WORDS + 8) begin
      step();
      waited++;
    end
    if (!o_dma_finish) begin
      $display("at %0t ns the weight load never raised o_dma_finish", $time);
      error_cnt++;
    end else begin
      if (check_timing) begin
        check_bit(waited == cnn_accel_pkg::TOTAL_WORDS + 2, 1'b1, "finish after edge 66");
      end
      step();
      check_bit(o_dma_finish, 1'b0, "o_dma_finish one cycle wide");
      check_bit(o_data_ready, 1'b1, "o_data_ready after finish");
    end
  endtask

  task automatic send_vector(input feat_vec_t v);
    for (int k = 0; k < cnn_accel_pkg::NUM_FEAT; k++) begin
      i_feat       = v[k];
      i_feat_valid = 1'b1;
      i_feat_last  = (k == cnn_accel_pkg::NUM_FEAT - 1);
      step();
    end
    last_cyc_q.push_back(cycle_cnt);                       // edge t of the last feature
    i_feat_valid = 1'b0;
    i_feat_last  = 1'b0;
  endtask

  task automatic wait_results(input int n);
    int waited;
    waited = 0;
    while (res_class_q.size() < n && waited < 3 * cnn_accel_pkg::NUM_FEAT + 8) begin
      step();
      waited++;
    end
  endtask

  task automatic take_result(input cnn_accel_pkg::class_idx_t exp_c,
                             input cnn_accel_pkg::acc_t exp_s, input string what);
    int lat;
    if (res_class_q.size() == 0) begin
      $display("at %0t ns the %s gave no o_result_valid pulse", $time, what);
      error_cnt++;
    end else begin
      lat = res_cyc_q.pop_front() - last_cyc_q.pop_front();
      check_class(res_class_q.pop_front(), exp_c, what);
      check_score(res_score_q.pop_front(), exp_s, what);
      check_bit(lat == 3, 1'b1, {what, " valid 3 cycles after last"});
    end
  endtask

  task automatic expect_no_result(input string what);
    repeat (8) step();                                     // longer than the pipeline
    check_cnt++;
    if (res_class_q.size() != 0) begin
      $display("at %0t ns the %s produced an o_result_valid pulse", $time, what);
      error_cnt++;
      res_class_q.delete();
      res_score_q.delete();
      res_cyc_q.delete();
    end
    last_cyc_q.delete();
  endtask

  task automatic report_test(input string name, input int err0);
    test_cnt++;
    $display("[%0t ns] %s: %s", $time, name, (error_cnt == err0) ? "ok" : "has errors");
  endtask

  task automatic after_reset();
    int err0;
    err0 = error_cnt;
    check_bit(o_dma_finish, 1'b0, "o_dma_finish after reset");
    check_bit(o_data_ready, 1'b0, "o_data_ready after reset");
    check_bit(o_result_valid, 1'b0, "o_result_valid after reset");
    check_addr(o_sram_weight_addr, '0, "sram address after reset");
    report_test("after_reset", err0);
  endtask

  task automatic load_timing();
    int err0;
    err0 = error_cnt;
    fill_pattern(1);
    load_weights(1'b1);
    repeat (3) begin
      step();
      check_bit(o_data_ready, 1'b1, "o_data_ready holds");
    end
    report_test("load_timing", err0);
  endtask

  task automatic directed_vectors();
    int        err0;
    int        c;
    feat_vec_t va;
    feat_vec_t vb;
    err0 = error_cnt;
    for (int a = 0; a < cnn_accel_pkg::TOTAL_WORDS; a++) begin
      c = a / cnn_accel_pkg::NUM_FEAT;                     // class -1, 1, 3/0, 0/3 split at k=8
      case (c)
        0: sram_mem[a] = -16'sd1;
        1: sram_mem[a] = 16'sd1;
        2: sram_mem[a] = (a % cnn_accel_pkg::NUM_FEAT < 8) ? 16'sd3 : 16'sd0;
        default: sram_mem[a] = (a % cnn_accel_pkg::NUM_FEAT < 8) ? 16'sd0 : 16'sd3;
      endcase
    end
    for (int k = 0; k < cnn_accel_pkg::NUM_FEAT; k++) begin
      va[k] = (k < 8) ? 8'sd3 : 8'sd1;                     // scores -32, 32, 72, 24
      vb[k] = 8'sd2;                                       // classes 2 and 3 tie at 48
    end
    load_weights(1'b0);
    send_vector(va);
    wait_results(1);
    take_result(2'd2, 32'sd72, "directed vector");
    send_vector(vb);
    wait_results(1);
    take_result(2'd2, 32'sd48, "tie vector");
    report_test("directed_vectors", err0);
  endtask

  task automatic random_vectors();
    int                        err0;
    feat_vec_t                 v [3];
    cnn_accel_pkg::class_idx_t exp_c [3];
    cnn_accel_pkg::acc_t       exp_s [3];
    err0 = error_cnt;
    fill_random();
    load_weights(1'b0);
    for (int i = 0; i < 3; i++) begin
      random_vector(v[i]);
      ref_classify(v[i], exp_c[i], exp_s[i]);
    end
    for (int i = 0; i < 3; i++) begin
      send_vector(v[i]);                                   // no gap between vectors
    end
    wait_results(3);
    for (int i = 0; i < 3; i++) begin
      take_result(exp_c[i], exp_s[i], "random vector");
    end
    report_test("random_vectors", err0);
  endtask

  task automatic ignored_features();
    int                        err0;
    feat_vec_t                 v;
    cnn_accel_pkg::class_idx_t exp_c;
    cnn_accel_pkg::acc_t       exp_s;
    err0 = error_cnt;
    apply_reset();
    random_vector(v);
    send_vector(v);
    expect_no_result("vector before any load");
    fill_random();
    load_weights(1'b0);
    fork
      load_weights(1'b0);
      begin
        repeat (4) step();                                 // well inside the reload
        send_vector(v);
      end
    join
    expect_no_result("vector during reload");
    ref_classify(v, exp_c, exp_s);
    send_vector(v);
    wait_results(1);
    take_result(exp_c, exp_s, "vector after load");
    saved_vec = v;
    report_test("ignored_features", err0);
  endtask

  task automatic reload_weights();
    int                        err0;
    cnn_accel_pkg::class_idx_t exp_c;
    cnn_accel_pkg::acc_t       exp_s;
    err0 = error_cnt;
    check_bit(o_data_ready, 1'b1, "o_data_ready before reload");
    fill_pattern(5);
    load_weights(1'b0);                                    // checks the drop and the rise
    ref_classify(saved_vec, exp_c, exp_s);
    send_vector(saved_vec);
    wait_results(1);
    take_result(exp_c, exp_s, "vector after reload");
    report_test("reload_weights", err0);
  endtask

  initial begin
    seed         = 32'h4f9f617d;
    rst_n        = 1'b0;
    i_start      = 1'b0;
    i_feat       = '0;
    i_feat_valid = 1'b0;
    i_feat_last  = 1'b0;
    sram_q       = '0;
    for (int a = 0; a < cnn_accel_pkg::TOTAL_WORDS; a++) begin
      sram_mem[a] = '0;
    end
    apply_reset();
    after_reset();
    load_timing();
    directed_vectors();
    random_vectors();
    ignored_features();
    reload_weights();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: cnn_accel.f
source/cnn_accel_pkg.sv
source/weight_bank_if.sv
source/weight_dma.sv
source/weight_bank.sv
source/fc_classifier.sv
source/cnn_accel_top.sv
verification/cnn_accel_tb.sv

// File: Bender.yml
package:
  name: cnn_accel

sources:
  - files:
      - source/cnn_accel_pkg.sv
      - source/weight_bank_if.sv
      - source/weight_dma.sv
      - source/weight_bank.sv
      - source/fc_classifier.sv
      - source/cnn_accel_top.sv
  - target: test
    files:
      - verification/cnn_accel_tb.sv
